//--- vram_subsystem.f
+incdir+include
verilog/vram_pkg.sv
verilog/bank_arbiter.sv
verilog/bank_ram.sv
verilog/client_return.sv
verilog/vram_subsystem.sv
sim/tb_vram_subsystem.sv

//--- run_sim.sh
#!/bin/sh
# build the testbench with Verilator, run it and look for the pass line

cd "$(dirname "$0")" || exit 1

verilator --binary --top-module tb_vram_subsystem -f vram_subsystem.f \
	-Mdir obj_dir -o sim_vram
if [ $? -ne 0 ]; then
	echo "verilator build failed"
	exit 1
fi

out=$(./obj_dir/sim_vram)
status=$?
printf '%s\n' "$out"
if [ $status -ne 0 ]; then
	echo "simulation exited with status $status"
	exit 1
fi

if printf '%s\n' "$out" | grep -qF '*** PASSED ***'; then
	exit 0
fi
echo "pass line not found in simulation output"
exit 1

//--- sim/tb_vram_subsystem.sv
`include "vram_consts.svh"

module tb_vram_subsystem
	import vram_pkg::*;
();

	timeunit 1ns;
	timeprecision 100ps;

	// 16 cpu, 24 fill and read back, 2 contention, 6 parallel, 4 per mix round
	localparam int MIX_ROUNDS = 30;
	localparam int PLANNED_ACCESSES = 16 + 24 + 2 + 6 + 4 * MIX_ROUNDS;
	localparam int CYCLE_LIMIT = 40 * PLANNED_ACCESSES + 200;
	localparam int FILL_WORDS = 8;
	// fill range straddles the bank 0 / bank 1 boundary
	localparam mem_addr_t FILL_BASE = 16'h3ffc;

	logic      CLK = 1'b0;
	logic      RSTb;
	mem_addr_t sprite_addr;
	logic      sprite_valid;
	logic      sprite_ready;
	mem_data_t sprite_data;
	mem_addr_t bg_addr;
	logic      bg_valid;
	logic      bg_ready;
	mem_data_t bg_data;
	mem_addr_t flash_addr;
	mem_data_t flash_wdata;
	logic      flash_valid;
	logic      flash_ready;
	mem_addr_t cpu_addr;
	mem_data_t cpu_wdata;
	logic      cpu_wr;
	logic      cpu_valid;
	logic      cpu_ready;
	mem_data_t cpu_rdata;

	// expected contents of the whole address space
	mem_data_t model [1 << `ADDR_W];
	// addresses that hold a known word
	mem_addr_t written [$];
	mem_addr_t cpu_addrs [8];

	int cycles = 0;
	int checks = 0;
	int errors = 0;
	int tests_run = 0;
	int tests_failed = 0;
	int errors_at_start = 0;

	// per client, indexed by mask bit
	int        rise   [`NUM_CLIENTS];
	int        lat    [`NUM_CLIENTS];
	mem_addr_t c_addr [`NUM_CLIENTS];
	mem_data_t c_data [`NUM_CLIENTS];
	logic      c_wr   [`NUM_CLIENTS];
	int        c_hold [`NUM_CLIENTS];

	vram_subsystem DUT (
		.CLK          (CLK),
		.RSTb         (RSTb),
		.sprite_addr  (sprite_addr),
		.sprite_valid (sprite_valid),
		.sprite_ready (sprite_ready),
		.sprite_data  (sprite_data),
		.bg_addr      (bg_addr),
		.bg_valid     (bg_valid),
		.bg_ready     (bg_ready),
		.bg_data      (bg_data),
		.flash_addr   (flash_addr),
		.flash_wdata  (flash_wdata),
		.flash_valid  (flash_valid),
		.flash_ready  (flash_ready),
		.cpu_addr     (cpu_addr),
		.cpu_wdata    (cpu_wdata),
		.cpu_wr       (cpu_wr),
		.cpu_valid    (cpu_valid),
		.cpu_ready    (cpu_ready),
		.cpu_rdata    (cpu_rdata)
	);

	always #5 CLK = ~CLK;

	always @(posedge CLK) begin
		cycles <= cycles + 1;
	end

	initial begin
		repeat (CYCLE_LIMIT) @(posedge CLK);
		$display("timeout: run did not finish within %0d cycles", CYCLE_LIMIT);
		$display("*** FAILED ***");
		$finish;
	end

	function automatic mem_data_t expected_read(input mem_addr_t a);
		return model[a];
	endfunction

	function automatic bank_sel_t bank_of(input mem_addr_t a);
		return a[`ADDR_W-1 -: $bits(bank_sel_t)];
	endfunction

	function automatic mem_addr_t rand_addr(input bank_sel_t b);
		mem_addr_t a;
		a = mem_addr_t'($urandom);
		a[`ADDR_W-1 -: $bits(bank_sel_t)] = b;
		return a;
	endfunction

	task automatic check_data(input string name, input mem_data_t got, input mem_data_t exp);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("error at %0t: %s got %h expected %h", $time, name, got, exp);
		end
	endtask

	task automatic check_ready(input string name, input logic got, input logic exp);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("error at %0t: %s got %b expected %b", $time, name, got, exp);
		end
	endtask

	task automatic end_test(input string name);
		tests_run++;
		if (errors == errors_at_start) begin
			$display("test %s: ok", name);
		end else begin
			tests_failed++;
			$display("test %s: failed with %0d errors", name, errors - errors_at_start);
		end
		errors_at_start = errors;
	endtask

	task automatic drive_request(input int client, input mem_addr_t a, input logic w,
			input mem_data_t d, input logic v);
		case (client)
			`CLIENT_SPRITE: begin
				sprite_addr  <= a;
				sprite_valid <= v;
			end
			`CLIENT_BG: begin
				bg_addr  <= a;
				bg_valid <= v;
			end
			`CLIENT_FLASH: begin
				flash_addr  <= a;
				flash_wdata <= d;
				flash_valid <= v;
			end
			default: begin
				cpu_addr  <= a;
				cpu_wdata <= d;
				cpu_wr    <= w;
				cpu_valid <= v;
			end
		endcase
	endtask

	function automatic logic ready_of(input int client);
		case (client)
			`CLIENT_SPRITE: return sprite_ready;
			`CLIENT_BG:     return bg_ready;
			`CLIENT_FLASH:  return flash_ready;
			default:        return cpu_ready;
		endcase
	endfunction

	// one handshake; rise is the cycle ready was first seen, l the edges waited
	task automatic access(input int client, input mem_addr_t a, input logic w,
			input mem_data_t d, input int hold, output int r, output int l);
		int start;
		@(posedge CLK);
		drive_request(client, a, w, d, 1'b1);
		@(negedge CLK);
		start = cycles;
		while (!ready_of(client)) begin
			@(negedge CLK);
		end
		r = cycles;
		l = r - start;
		repeat (hold) @(negedge CLK);
		@(posedge CLK);
		drive_request(client, a, w, d, 1'b0);
	endtask

	// compare process, outputs are settled at the falling edge
	initial begin
		forever begin
			@(negedge CLK);
			if (RSTb) begin
				// a write is in the ram once its ready shows
				if (flash_ready) begin
					model[flash_addr] = flash_wdata;
				end
				if (cpu_ready && cpu_wr) begin
					model[cpu_addr] = cpu_wdata;
				end
				if (sprite_ready) begin
					check_data("sprite_data", sprite_data, expected_read(sprite_addr));
				end else begin
					check_data("sprite_data", sprite_data, '0);
				end
				if (bg_ready) begin
					check_data("bg_data", bg_data, expected_read(bg_addr));
				end else begin
					check_data("bg_data", bg_data, '0);
				end
				if (!cpu_ready) begin
					check_data("cpu_rdata", cpu_rdata, '0);
				end else if (!cpu_wr) begin
					check_data("cpu_rdata", cpu_rdata, expected_read(cpu_addr));
				end
			end
		end
	end

	initial begin
		mem_addr_t a_flash;
		mem_addr_t a_cpu;

		void'($urandom(16821));
		RSTb         = 1'b0;
		sprite_addr  = '0;
		sprite_valid = 1'b0;
		bg_addr      = '0;
		bg_valid     = 1'b0;
		flash_addr   = '0;
		flash_wdata  = '0;
		flash_valid  = 1'b0;
		cpu_addr     = '0;
		cpu_wdata    = '0;
		cpu_wr       = 1'b0;
		cpu_valid    = 1'b0;
		repeat (5) @(posedge CLK);
		RSTb <= 1'b1;

		// idle outputs after reset
		@(negedge CLK);
		check_ready("sprite_ready", sprite_ready, 1'b0);
		check_ready("bg_ready", bg_ready, 1'b0);
		check_ready("flash_ready", flash_ready, 1'b0);
		check_ready("cpu_ready", cpu_ready, 1'b0);
		check_data("sprite_data", sprite_data, '0);
		check_data("bg_data", bg_data, '0);
		check_data("cpu_rdata", cpu_rdata, '0);
		end_test("reset_idle");

		// cpu writes two words per bank, then reads them back
		for (int i = 0; i < 8; i++) begin
			cpu_addrs[i] = rand_addr(bank_sel_t'(i % 4));
			access(`CLIENT_CPU, cpu_addrs[i], 1'b1, mem_data_t'($urandom), 0,
				rise[3], lat[3]);
			check_ready("cpu_ready one edge after write valid", lat[3] == 1, 1'b1);
			written.push_back(cpu_addrs[i]);
		end
		for (int i = 0; i < 8; i++) begin
			access(`CLIENT_CPU, cpu_addrs[i], 1'b0, '0, 0, rise[3], lat[3]);
			check_ready("cpu_ready one edge after read valid", lat[3] == 1, 1'b1);
		end
		end_test("cpu_write_read");

		// flash fill across a bank boundary, sprite and bg read it back
		for (int k = 0; k < FILL_WORDS; k++) begin
			access(`CLIENT_FLASH, mem_addr_t'(FILL_BASE + k), 1'b1,
				mem_data_t'($urandom), 0, rise[2], lat[2]);
			written.push_back(mem_addr_t'(FILL_BASE + k));
		end
		fork
			begin
				for (int k = 0; k < FILL_WORDS; k++) begin
					access(`CLIENT_SPRITE, mem_addr_t'(FILL_BASE + k), 1'b0, '0, 0,
						rise[0], lat[0]);
				end
			end
			begin
				for (int k = FILL_WORDS - 1; k >= 0; k--) begin
					access(`CLIENT_BG, mem_addr_t'(FILL_BASE + k), 1'b0, '0, 0,
						rise[1], lat[1]);
				end
			end
		join
		end_test("flash_fill_readback");

		// sprite and cpu collide in bank 2
		fork
			access(`CLIENT_SPRITE, cpu_addrs[2], 1'b0, '0, 2, rise[0], lat[0]);
			access(`CLIENT_CPU, cpu_addrs[6], 1'b0, '0, 0, rise[3], lat[3]);
		join
		check_ready("sprite_ready rises before cpu_ready", rise[0] < rise[3], 1'b1);
		check_ready("cpu_ready low until sprite drops valid", rise[3] > rise[0] + 3, 1'b1);
		end_test("same_bank_priority");

		// four clients, four banks, one cycle
		a_flash = rand_addr(bank_sel_t'(2));
		a_cpu   = rand_addr(bank_sel_t'(3));
		fork
			access(`CLIENT_SPRITE, cpu_addrs[0], 1'b0, '0, 0, rise[0], lat[0]);
			access(`CLIENT_BG, cpu_addrs[1], 1'b0, '0, 0, rise[1], lat[1]);
			access(`CLIENT_FLASH, a_flash, 1'b1, mem_data_t'($urandom), 0, rise[2], lat[2]);
			access(`CLIENT_CPU, a_cpu, 1'b1, mem_data_t'($urandom), 0, rise[3], lat[3]);
		join
		check_ready("sprite_ready one edge after valid", lat[0] == 1, 1'b1);
		check_ready("bg_ready with sprite_ready", rise[1] == rise[0], 1'b1);
		check_ready("flash_ready with sprite_ready", rise[2] == rise[0], 1'b1);
		check_ready("cpu_ready with sprite_ready", rise[3] == rise[0], 1'b1);
		written.push_back(a_flash);
		written.push_back(a_cpu);
		access(`CLIENT_CPU, a_flash, 1'b0, '0, 0, rise[3], lat[3]);
		access(`CLIENT_CPU, a_cpu, 1'b0, '0, 0, rise[3], lat[3]);
		end_test("parallel_banks");

		// random mix, every client starts in the same cycle
		for (int r = 0; r < MIX_ROUNDS; r++) begin
			for (int c = 0; c < `NUM_CLIENTS; c++) begin
				c_hold[c] = $urandom % 4;
				c_data[c] = mem_data_t'($urandom);
				c_wr[c]   = (c == `CLIENT_FLASH);
				c_addr[c] = written[$urandom % written.size()];
			end
			c_wr[`CLIENT_CPU] = ($urandom % 2) == 1;
			c_addr[`CLIENT_FLASH] = rand_addr(bank_sel_t'($urandom % 4));
			if (c_wr[`CLIENT_CPU]) begin
				c_addr[`CLIENT_CPU] = rand_addr(bank_sel_t'($urandom % 4));
			end
			fork
				access(0, c_addr[0], c_wr[0], c_data[0], c_hold[0], rise[0], lat[0]);
				access(1, c_addr[1], c_wr[1], c_data[1], c_hold[1], rise[1], lat[1]);
				access(2, c_addr[2], c_wr[2], c_data[2], c_hold[2], rise[2], lat[2]);
				access(3, c_addr[3], c_wr[3], c_data[3], c_hold[3], rise[3], lat[3]);
			join
			// lower mask bit must win inside a shared bank
			for (int i = 0; i < `NUM_CLIENTS; i++) begin
				for (int j = i + 1; j < `NUM_CLIENTS; j++) begin
					if (bank_of(c_addr[i]) == bank_of(c_addr[j])) begin
						check_ready($sformatf("ready of client %0d before client %0d", i, j),
							rise[i] < rise[j], 1'b1);
					end
				end
			end
			written.push_back(c_addr[`CLIENT_FLASH]);
			if (c_wr[`CLIENT_CPU]) begin
				written.push_back(c_addr[`CLIENT_CPU]);
			end
		end
		end_test("random_mix");

		repeat (2) @(negedge CLK);
		$display("summary: %0d tests, %0d failed, %0d checks, %0d errors",
			tests_run, tests_failed, checks, errors);
		if (errors == 0) begin
			$display("*** PASSED ***");
		end else begin
			$display("*** FAILED ***");
		end
		$finish;
	end

endmodule

//--- verilog/vram_subsystem.sv
`include "vram_consts.svh"

module vram_subsystem
	import vram_pkg::*;
(
	input  logic      CLK,
	input  logic      RSTb,

	input  mem_addr_t sprite_addr,
	input  logic      sprite_valid,
	output logic      sprite_ready,
	output mem_data_t sprite_data,

	input  mem_addr_t bg_addr,
	input  logic      bg_valid,
	output logic      bg_ready,
	output mem_data_t bg_data,

	input  mem_addr_t flash_addr,
	input  mem_data_t flash_wdata,
	input  logic      flash_valid,
	output logic      flash_ready,

	input  mem_addr_t cpu_addr,
	input  mem_data_t cpu_wdata,
	input  logic      cpu_wr,
	input  logic      cpu_valid,
	output logic      cpu_ready,
	output mem_data_t cpu_rdata
);

	bank_addr_t   ram_addr  [`VRAM_BANKS];
	mem_data_t    ram_wdata [`VRAM_BANKS];
	logic         ram_wr    [`VRAM_BANKS];
	mem_data_t    ram_rdata [`VRAM_BANKS];
	client_mask_t grant     [`VRAM_BANKS];

	// one arbiter and one ram per bank, banks run independently
	for (genvar b = 0; b < `VRAM_BANKS; b++) begin : g_bank
		bank_arbiter #(.BANK_ID(b)) u_arb (
			.CLK          (CLK),
			.RSTb         (RSTb),
			.sprite_addr  (sprite_addr),
			.sprite_valid (sprite_valid),
			.bg_addr      (bg_addr),
			.bg_valid     (bg_valid),
			.flash_addr   (flash_addr),
			.flash_wdata  (flash_wdata),
			.flash_valid  (flash_valid),
			.cpu_addr     (cpu_addr),
			.cpu_wdata    (cpu_wdata),
			.cpu_wr       (cpu_wr),
			.cpu_valid    (cpu_valid),
			.ram_addr     (ram_addr[b]),
			.ram_wdata    (ram_wdata[b]),
			.ram_wr       (ram_wr[b]),
			.grant        (grant[b])
		);

		bank_ram u_ram (
			.CLK   (CLK),
			.addr  (ram_addr[b]),
			.wdata (ram_wdata[b]),
			.wr    (ram_wr[b]),
			.rdata (ram_rdata[b])
		);
	end

	client_return u_return (
		.grant0       (grant[0]),
		.grant1       (grant[1]),
		.grant2       (grant[2]),
		.grant3       (grant[3]),
		.rdata0       (ram_rdata[0]),
		.rdata1       (ram_rdata[1]),
		.rdata2       (ram_rdata[2]),
		.rdata3       (ram_rdata[3]),
		.sprite_ready (sprite_ready),
		.sprite_data  (sprite_data),
		.bg_ready     (bg_ready),
		.bg_data      (bg_data),
		.flash_ready  (flash_ready),
		.cpu_ready    (cpu_ready),
		.cpu_rdata    (cpu_rdata)
	);

endmodule

//--- verilog/client_return.sv
`include "vram_consts.svh"

module client_return
	import vram_pkg::*;
(
	// grant mask of each bank arbiter
	input  client_mask_t grant0,
	input  client_mask_t grant1,
	input  client_mask_t grant2,
	input  client_mask_t grant3,

	// registered read data of each bank ram
	input  mem_data_t    rdata0,
	input  mem_data_t    rdata1,
	input  mem_data_t    rdata2,
	input  mem_data_t    rdata3,

	output logic         sprite_ready,
	output mem_data_t    sprite_data,

	output logic         bg_ready,
	output mem_data_t    bg_data,

	output logic         flash_ready,

	output logic         cpu_ready,
	output mem_data_t    cpu_rdata
);

	client_mask_t grants [`VRAM_BANKS];
	mem_data_t    rdatas [`VRAM_BANKS];

	assign grants[0] = grant0;
	assign grants[1] = grant1;
	assign grants[2] = grant2;
	assign grants[3] = grant3;

	assign rdatas[0] = rdata0;
	assign rdatas[1] = rdata1;
	assign rdatas[2] = rdata2;
	assign rdatas[3] = rdata3;

	// a client's address hits one bank only,
	// so at most one grant bit per client is set
	always_comb begin
		sprite_ready = 1'b0;
		sprite_data  = '0;
		bg_ready     = 1'b0;
		bg_data      = '0;
		flash_ready  = 1'b0;
		cpu_ready    = 1'b0;
		cpu_rdata    = '0;

		for (int b = 0; b < `VRAM_BANKS; b++) begin
			if (grants[b][`CLIENT_SPRITE]) begin
				sprite_ready = 1'b1;
				sprite_data  = rdatas[b];
			end
			if (grants[b][`CLIENT_BG]) begin
				bg_ready = 1'b1;
				bg_data  = rdatas[b];
			end
			// flash only writes, no data back
			if (grants[b][`CLIENT_FLASH]) begin
				flash_ready = 1'b1;
			end
			if (grants[b][`CLIENT_CPU]) begin
				cpu_ready = 1'b1;
				cpu_rdata = rdatas[b];
			end
		end
	end

endmodule

//--- verilog/bank_ram.sv
`include "vram_consts.svh"

module bank_ram
	import vram_pkg::*;
(
	input  logic       CLK,
	input  bank_addr_t addr,
	input  mem_data_t  wdata,
	input  logic       wr,
	output mem_data_t  rdata
);

	localparam int DEPTH = 1 << `BANK_ADDR_W;

	mem_data_t mem [DEPTH];

	// single port, registered read
	// read during write on one address gives the old word
	always_ff @(posedge CLK) begin
		if (wr) begin
			mem[addr] <= wdata;
		end
		rdata <= mem[addr];
	end

endmodule

//--- verilog/bank_arbiter.sv
`include "vram_consts.svh"

module bank_arbiter
	import vram_pkg::*;
#(
	parameter int BANK_ID = 0
)
(
	input  logic         CLK,
	input  logic         RSTb,

	// sprite fetcher, read only
	input  mem_addr_t    sprite_addr,
	input  logic         sprite_valid,

	// background fetcher, read only
	input  mem_addr_t    bg_addr,
	input  logic         bg_valid,

	// flash loader, write only
	input  mem_addr_t    flash_addr,
	input  mem_data_t    flash_wdata,
	input  logic         flash_valid,

	// cpu, read and write
	input  mem_addr_t    cpu_addr,
	input  mem_data_t    cpu_wdata,
	input  logic         cpu_wr,
	input  logic         cpu_valid,

	// bank ram side
	output bank_addr_t   ram_addr,
	output mem_data_t    ram_wdata,
	output logic         ram_wr,

	// owner of this bank, zero while idle
	output client_mask_t grant
);

	localparam bank_sel_t MY_BANK = bank_sel_t'(BANK_ID);

	bank_state_e state;
	bank_state_e state_next;

	logic sprite_hit;
	logic bg_hit;
	logic flash_hit;
	logic cpu_hit;

	// top address bits select the bank
	function automatic logic in_bank(input mem_addr_t addr);
		return addr[`ADDR_W-1 -: $bits(bank_sel_t)] == MY_BANK;
	endfunction

	function automatic bank_addr_t local_addr(input mem_addr_t addr);
		return addr[`BANK_ADDR_W-1:0];
	endfunction

	// requests that fall in this bank
	assign sprite_hit = sprite_valid && in_bank(sprite_addr);
	assign bg_hit     = bg_valid && in_bank(bg_addr);
	assign flash_hit  = flash_valid && in_bank(flash_addr);
	assign cpu_hit    = cpu_valid && in_bank(cpu_addr);

	always_ff @(posedge CLK) begin
		if (!RSTb) begin
			state <= ST_IDLE;
		end else begin
			state <= state_next;
		end
	end

	always_comb begin
		state_next = state;
		ram_addr   = '0;
		ram_wdata  = '0;
		ram_wr     = 1'b0;
		grant      = '0;

		case (state)
			ST_IDLE: begin
				// fixed priority: sprite, bg, flash, cpu
				// the winner's address goes out now so the ram sees it this edge
				if (sprite_hit) begin
					ram_addr   = local_addr(sprite_addr);
					state_next = ST_SPRITE;
				end else if (bg_hit) begin
					ram_addr   = local_addr(bg_addr);
					state_next = ST_BG;
				end else if (flash_hit) begin
					ram_addr   = local_addr(flash_addr);
					ram_wdata  = flash_wdata;
					ram_wr     = 1'b1;
					state_next = ST_FLASH;
				end else if (cpu_hit) begin
					ram_addr   = local_addr(cpu_addr);
					ram_wdata  = cpu_wdata;
					ram_wr     = cpu_wr;
					state_next = ST_CPU;
				end
			end

			ST_SPRITE: begin
				ram_addr = local_addr(sprite_addr);
				grant[`CLIENT_SPRITE] = 1'b1;
				if (!sprite_valid) begin
					state_next = ST_IDLE;
				end
			end

			ST_BG: begin
				ram_addr = local_addr(bg_addr);
				grant[`CLIENT_BG] = 1'b1;
				if (!bg_valid) begin
					state_next = ST_IDLE;
				end
			end

			ST_FLASH: begin
				// same word rewritten while valid is held
				ram_addr  = local_addr(flash_addr);
				ram_wdata = flash_wdata;
				ram_wr    = flash_valid;
				grant[`CLIENT_FLASH] = 1'b1;
				if (!flash_valid) begin
					state_next = ST_IDLE;
				end
			end

			ST_CPU: begin
				ram_addr  = local_addr(cpu_addr);
				ram_wdata = cpu_wdata;
				ram_wr    = cpu_valid && cpu_wr;
				grant[`CLIENT_CPU] = 1'b1;
				if (!cpu_valid) begin
					state_next = ST_IDLE;
				end
			end

			default: begin
				state_next = ST_IDLE;
			end
		endcase
	end

endmodule

//--- verilog/vram_pkg.sv
`include "vram_consts.svh"

package vram_pkg;

	// full client word address
	typedef logic [`ADDR_W-1:0] mem_addr_t;

	// address seen by a single bank ram
	typedef logic [`BANK_ADDR_W-1:0] bank_addr_t;

	// one video memory word
	typedef logic [`DATA_W-1:0] mem_data_t;

	// bank number, taken from the top address bits
	typedef logic [$clog2(`VRAM_BANKS)-1:0] bank_sel_t;

	// one bit per client, see CLIENT_* in the consts header
	typedef logic [`NUM_CLIENTS-1:0] client_mask_t;

	// per-bank arbiter state
	// one grant state per client
	typedef enum logic [2:0] {
		ST_IDLE,
		ST_SPRITE,
		ST_BG,
		ST_FLASH,
		ST_CPU
	} bank_state_e;

endpackage

//--- include/vram_consts.svh
`ifndef VRAM_CONSTS_SVH
`define VRAM_CONSTS_SVH

// bank layout of the video memory
`define VRAM_BANKS 4

// word width shared by every client and bank
`define DATA_W 16

// client word address, top bits pick the bank
`define ADDR_W 16

// word address inside one 16K bank
`define BANK_ADDR_W 14

// sprite, background, flash, cpu
`define NUM_CLIENTS 4

// bit positions in a client mask
// lower index wins inside a bank
`define CLIENT_SPRITE 0
`define CLIENT_BG     1
`define CLIENT_FLASH  2
`define CLIENT_CPU    3

`endif
